// File: include/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width of one lane
`define EXEC_XLEN 32

// depth of the DSP-style multiplier pipeline
`define EXEC_MULT_CYCLES 4

// restoring divider, one quotient bit per iteration
`define EXEC_DIV_STEPS 32

`endif

// File: design/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]   word_t;
    // HI in the upper half
    typedef logic [2*`EXEC_XLEN-1:0] dword_t;
    typedef logic [15:0]             imm_t;
    typedef logic [4:0]              shamt_t;
    typedef logic [4:0]              reg_idx_t;

    typedef enum logic [2:0] {OP_ALU, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
                              OP_LOAD, OP_STORE} op_t;

    typedef enum logic [3:0] {ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
                              SLT, SLTU, SLL, SRL, SRA, LUI} alufunc_t;

    typedef enum logic {REGB, IMM} alusrc_t;

    typedef enum logic [1:0] {MSIZE1, MSIZE2, MSIZE4} msize_t;

    typedef struct packed {
        op_t      op;
        alufunc_t alufunc;
        alusrc_t  alusrc;
        logic     zeroext;
        logic     shamt_valid;
        logic     is_link;
        logic     memtoreg;
        logic     memwrite;
        msize_t   msize;
    } ctl_t;

    typedef struct packed {
        logic  overflow;
        logic  adel;
        logic  ades;
        word_t vaddr;
    } exc_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        shamt_t   shamt;
        imm_t     imm;
        word_t    rd1;
        word_t    rd2;
        reg_idx_t rdst;
        ctl_t     ctl;
    } issue_data_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    alu_out;
        word_t    srca;
        word_t    srcb;
        reg_idx_t rdst;
        ctl_t     ctl;
        dword_t   hilo;
        exc_t     exc;
    } execute_data_t;

endpackage

// File: design/hilo_if.sv
`timescale 1ns/1ps

interface hilo_if;

    // request levels, held by the stage until busy drops
    logic             mul_req;
    logic             div_req;
    logic             is_signed;
    exec_pkg::word_t  opa;
    exec_pkg::word_t  opb;

    exec_pkg::dword_t result;
    logic             busy;

    modport stage (output mul_req, div_req, is_signed, opa, opb,
                   input  result, busy);

    modport unit  (input  mul_req, div_req, is_signed, opa, opb,
                   output result, busy);

endinterface

// File: design/exec_alu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_alu (
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    input  exec_pkg::alufunc_t func_i,
    output exec_pkg::word_t    result_o,
    output logic               overflow_o
);
    import exec_pkg::*;

    localparam int MSB = `EXEC_XLEN - 1;

    word_t  sum;
    word_t  diff;
    shamt_t sh;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    // shift amount rides on operand a
    assign sh   = a_i[4:0];

    always_comb begin
        unique case (func_i)
            ADD, ADDU: result_o = sum;
            SUB, SUBU: result_o = diff;
            AND:       result_o = a_i & b_i;
            OR:        result_o = a_i | b_i;
            XOR:       result_o = a_i ^ b_i;
            NOR:       result_o = ~(a_i | b_i);
            SLT:       result_o = word_t'($signed(a_i) < $signed(b_i));
            SLTU:      result_o = word_t'(a_i < b_i);
            SLL:       result_o = b_i << sh;
            SRL:       result_o = b_i >> sh;
            SRA:       result_o = word_t'($signed(b_i) >>> sh);
            LUI:       result_o = b_i << 16;
            default:   result_o = '0;
        endcase
    end

    // only the trapping signed forms report overflow
    always_comb begin
        unique case (func_i)
            ADD: begin
                // same operand signs but the sum flips
                overflow_o = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
            end
            SUB: begin
                overflow_o = (a_i[MSB] != b_i[MSB]) && (diff[MSB] != a_i[MSB]);
            end
            default: begin
                overflow_o = 1'b0;
            end
        endcase
    end

endmodule

// File: design/exec_multiplier.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_multiplier (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             start_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             done_o,
    output exec_pkg::dword_t product_o
);
    import exec_pkg::*;

    localparam int DEPTH = `EXEC_MULT_CYCLES;

    dword_t           stage_q [DEPTH];
    logic [DEPTH-1:0] vld_q;

    // token walks alongside the product
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[DEPTH-2:0], start_i};
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            stage_q[0] <= dword_t'(a_i) * dword_t'(b_i);
        end
        for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    assign done_o    = vld_q[DEPTH-1];
    assign product_o = stage_q[DEPTH-1];

    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !(|vld_q))
        else $error("multiplier started while a product is in flight");

endmodule

// File: design/exec_divider.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_divider (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             start_i,
    input  exec_pkg::word_t  dividend_i,
    input  exec_pkg::word_t  divisor_i,
    output logic             done_o,
    output exec_pkg::dword_t result_o
);
    import exec_pkg::*;

    localparam int STEPS = `EXEC_DIV_STEPS;
    localparam int CNT_W = $clog2(STEPS);
    localparam int MSB   = `EXEC_XLEN - 1;

    typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_t;

    div_state_t         state_q;
    logic [CNT_W-1:0]   step_q;
    word_t              rem_q;
    word_t              quot_q;
    word_t              divisor_q;
    logic [`EXEC_XLEN:0] trial;

    // next dividend bit shifted into the partial remainder, minus divisor
    assign trial = {rem_q, quot_q[MSB]} - {1'b0, divisor_q};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        step_q  <= '0;
                    end
                end
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(STEPS - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // a zero divisor never borrows, so the quotient fills with ones
    // and the remainder ends up as the dividend
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            rem_q     <= '0;
            quot_q    <= dividend_i;
            divisor_q <= divisor_i;
        end else if (state_q == RUN) begin
            if (trial[`EXEC_XLEN]) begin
                // borrow, keep the shifted remainder
                rem_q  <= {rem_q[MSB-1:0], quot_q[MSB]};
                quot_q <= {quot_q[MSB-1:0], 1'b0};
            end else begin
                rem_q  <= trial[MSB:0];
                quot_q <= {quot_q[MSB-1:0], 1'b1};
            end
        end
    end

    assign done_o   = (state_q == DONE);
    assign result_o = {rem_q, quot_q};

endmodule

// File: design/exec_hilo_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_hilo_unit (
    input logic  clk,
    input logic  arst_n_i,
    hilo_if.unit hilo
);
    import exec_pkg::*;

    localparam int MSB = `EXEC_XLEN - 1;

    typedef enum logic {IDLE, WAIT} hilo_state_t;

    hilo_state_t state_q;
    logic        sel_div_q;
    logic        neg_res_q;
    logic        neg_rem_q;
    logic        neg_a;
    logic        neg_b;
    word_t       mag_a;
    word_t       mag_b;
    logic        mul_start;
    logic        div_start;
    logic        start;
    logic        mul_done;
    logic        div_done;
    logic        done;
    dword_t      product;
    dword_t      div_res;
    word_t       quot;
    word_t       rem;

    // core units only see magnitudes
    assign neg_a = hilo.is_signed & hilo.opa[MSB];
    assign neg_b = hilo.is_signed & hilo.opb[MSB];
    assign mag_a = neg_a ? -hilo.opa : hilo.opa;
    assign mag_b = neg_b ? -hilo.opb : hilo.opb;

    // request level becomes a single start pulse
    assign mul_start = (state_q == IDLE) & hilo.mul_req;
    assign div_start = (state_q == IDLE) & hilo.div_req & ~hilo.mul_req;
    assign start     = mul_start | div_start;
    assign done      = sel_div_q ? div_done : mul_done;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IDLE;
            sel_div_q <= 1'b0;
            neg_res_q <= 1'b0;
            neg_rem_q <= 1'b0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q   <= WAIT;
                        sel_div_q <= div_start;
                        neg_res_q <= neg_a ^ neg_b;
                        // remainder follows the dividend
                        neg_rem_q <= neg_a;
                    end
                end
                WAIT: begin
                    if (done) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    exec_multiplier i_mult (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (mul_start),
        .a_i       (mag_a),
        .b_i       (mag_b),
        .done_o    (mul_done),
        .product_o (product)
    );

    exec_divider i_div (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start),
        .dividend_i (mag_a),
        .divisor_i  (mag_b),
        .done_o     (div_done),
        .result_o   (div_res)
    );

    assign quot = neg_res_q ? -div_res[MSB:0] : div_res[MSB:0];
    assign rem  = neg_rem_q ? -div_res[2*`EXEC_XLEN-1:`EXEC_XLEN]
                            : div_res[2*`EXEC_XLEN-1:`EXEC_XLEN];

    assign hilo.result = sel_div_q ? {rem, quot} : (neg_res_q ? -product : product);
    // low again in the completion cycle
    assign hilo.busy   = (state_q == IDLE) ? start : ~done;

endmodule

// File: design/dual_execute.sv
`timescale 1ns/1ps

module dual_execute (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  exec_pkg::issue_data_t   [1:0] issue_i,
    output exec_pkg::execute_data_t [1:0] exec_o,
    output logic                          e_wait_o
);
    import exec_pkg::*;

    word_t [1:0] alu_res;
    logic  [1:0] alu_ovf;
    logic  [1:0] load_mis;
    logic  [1:0] store_mis;
    logic        md_lane;
    logic        md_any;
    op_t         md_op;

    hilo_if hilo ();

    function automatic logic is_muldiv(op_t op);
        return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    endfunction

    for (genvar i = 0; i < 2; i++) begin : g_lane
        word_t ext_imm;
        word_t alu_a;
        word_t alu_b;
        logic  misaligned;

        assign ext_imm = issue_i[i].ctl.zeroext ? {16'b0, issue_i[i].imm}
                                                : {{16{issue_i[i].imm[15]}}, issue_i[i].imm};
        assign alu_a   = issue_i[i].ctl.shamt_valid ? word_t'(issue_i[i].shamt)
                                                    : issue_i[i].rd1;
        assign alu_b   = (issue_i[i].ctl.alusrc == IMM) ? ext_imm : issue_i[i].rd2;

        exec_alu i_alu (
            .a_i        (alu_a),
            .b_i        (alu_b),
            .func_i     (issue_i[i].ctl.alufunc),
            .result_o   (alu_res[i]),
            .overflow_o (alu_ovf[i])
        );

        // address is the raw ALU sum
        assign misaligned   = (issue_i[i].ctl.msize == MSIZE2 && alu_res[i][0]) ||
                              (issue_i[i].ctl.msize == MSIZE4 && alu_res[i][1:0] != 2'b00);
        assign load_mis[i]  = issue_i[i].ctl.memtoreg & misaligned;
        assign store_mis[i] = issue_i[i].ctl.memwrite & misaligned;
    end

    // older lane wins the HI/LO unit
    assign md_lane = is_muldiv(issue_i[1].ctl.op);
    assign md_op   = issue_i[md_lane].ctl.op;
    assign md_any  = is_muldiv(md_op);

    assign hilo.mul_req   = md_op inside {OP_MULT, OP_MULTU};
    assign hilo.div_req   = md_op inside {OP_DIV, OP_DIVU};
    assign hilo.is_signed = md_op inside {OP_MULT, OP_DIV};
    assign hilo.opa       = issue_i[md_lane].rd1;
    assign hilo.opb       = issue_i[md_lane].rd2;
    assign e_wait_o       = hilo.busy;

    exec_hilo_unit i_hilo_unit (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hilo     (hilo)
    );

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            exec_o[i].valid        = issue_i[i].valid;
            exec_o[i].pc           = issue_i[i].pc;
            exec_o[i].alu_out      = alu_res[i];
            exec_o[i].srca         = issue_i[i].rd1;
            exec_o[i].srcb         = issue_i[i].rd2;
            exec_o[i].rdst         = issue_i[i].rdst;
            exec_o[i].ctl          = issue_i[i].ctl;
            exec_o[i].hilo         = '0;
            exec_o[i].exc.overflow = alu_ovf[i];
            exec_o[i].exc.adel     = load_mis[i];
            exec_o[i].exc.ades     = store_mis[i];
            exec_o[i].exc.vaddr    = (load_mis[i] | store_mis[i]) ? alu_res[i] : '0;
            if (load_mis[i]) begin
                exec_o[i].ctl.memtoreg = 1'b0;
            end
            if (store_mis[i]) begin
                exec_o[i].ctl.memwrite = 1'b0;
            end
        end
        if (issue_i[1].ctl.is_link) begin
            exec_o[1].alu_out = issue_i[1].pc + word_t'(8);
        end
        // a faulting older access blocks the younger one
        if (load_mis[1] | store_mis[1]) begin
            exec_o[0].ctl.memtoreg = 1'b0;
            exec_o[0].ctl.memwrite = 1'b0;
        end
        if (alu_ovf[1]) begin
            exec_o[0].valid = 1'b0;
        end
        if (md_any) begin
            exec_o[md_lane].hilo = hilo.result;
        end
    end

    a_hold_on_wait: assert property (@(posedge clk) disable iff (!arst_n_i)
        e_wait_o |=> $stable(issue_i))
        else $error("issue inputs changed while the stage was stalled");

    a_single_muldiv: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(is_muldiv(issue_i[1].ctl.op) && is_muldiv(issue_i[0].ctl.op)))
        else $error("both lanes issued a multiply/divide");

endmodule

// File: test/tb_dual_execute.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_dual_execute;
    import exec_pkg::*;

    typedef issue_data_t   [1:0] issue_pair_t;
    typedef execute_data_t [1:0] exec_pair_t;

    localparam int NUM_PAIRS  = 300;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        arst_n_i;
    issue_pair_t issue_i;
    exec_pair_t  exec_o;
    logic        e_wait_o;
    word_t       rng_state;
    logic        cmp_go;

    dual_execute i_dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .issue_i  (issue_i),
        .exec_o   (exec_o),
        .e_wait_o (e_wait_o)
    );

    always #4 clk = ~clk;

    // two LCG steps with the high half of each
    function automatic word_t next_rand();
        word_t hi;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        hi = {rng_state[31:16], 16'b0};
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return hi | {16'b0, rng_state[31:16]};
    endfunction

    function automatic word_t pick(word_t n);
        return next_rand() % n;
    endfunction

    function automatic word_t rand_operand();
        word_t sel;
        sel = pick(8);
        if (sel == 0) return 32'h8000_0000;
        if (sel == 1) return 32'h7fff_ffff;
        if (sel == 2) return 32'hffff_ffff;
        return next_rand();
    endfunction

    function automatic logic is_md(op_t op);
        return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    endfunction

    function automatic word_t alu_ref(alufunc_t f, word_t a, word_t b, output logic ovf);
        logic [32:0] wide;
        ovf = 1'b0;
        case (f)
            ADD: begin
                wide = {a[31], a} + {b[31], b};
                ovf  = wide[32] ^ wide[31];
                return wide[31:0];
            end
            SUB: begin
                wide = {a[31], a} - {b[31], b};
                ovf  = wide[32] ^ wide[31];
                return wide[31:0];
            end
            ADDU:    return a + b;
            SUBU:    return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            NOR:     return ~(a | b);
            SLT:     return {31'b0, $signed(a) < $signed(b)};
            SLTU:    return {31'b0, a < b};
            SLL:     return b << a[4:0];
            SRL:     return b >> a[4:0];
            SRA:     return $signed(b) >>> a[4:0];
            LUI:     return {b[15:0], 16'b0};
            default: return '0;
        endcase
    endfunction

    // signed forms work on magnitudes and restore the signs afterwards
    function automatic dword_t hilo_ref(op_t op, word_t a, word_t b);
        longint sa;
        longint sb;
        logic   neg_a;
        logic   neg_b;
        word_t  ma;
        word_t  mb;
        word_t  q;
        word_t  r;
        if (op == OP_MULT) begin
            sa = $signed(a);
            sb = $signed(b);
            return dword_t'(sa * sb);
        end
        if (op == OP_MULTU) return {32'b0, a} * {32'b0, b};
        if (!(op inside {OP_DIV, OP_DIVU})) return '0;
        neg_a = (op == OP_DIV) && a[31];
        neg_b = (op == OP_DIV) && b[31];
        ma = neg_a ? -a : a;
        mb = neg_b ? -b : b;
        if (mb == 0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (neg_a != neg_b) q = -q;
        if (neg_a) r = -r;
        return {r, q};
    endfunction

    function automatic word_t stall_ref(issue_pair_t iss);
        op_t op;
        op = is_md(iss[1].ctl.op) ? iss[1].ctl.op : iss[0].ctl.op;
        if (op inside {OP_MULT, OP_MULTU}) return `EXEC_MULT_CYCLES;
        if (op inside {OP_DIV, OP_DIVU}) return `EXEC_DIV_STEPS + 1;
        return 0;
    endfunction

    function automatic exec_pair_t model_execute(issue_pair_t iss);
        exec_pair_t exp;
        word_t      imm_x;
        word_t      opa;
        word_t      opb;
        word_t      res;
        logic       ovf;
        logic       bad;
        logic [1:0] fault;
        logic       md_lane;
        for (int i = 0; i < 2; i++) begin
            imm_x = iss[i].ctl.zeroext ? {16'b0, iss[i].imm}
                                       : {{16{iss[i].imm[15]}}, iss[i].imm};
            opa = iss[i].ctl.shamt_valid ? {27'b0, iss[i].shamt} : iss[i].rd1;
            opb = (iss[i].ctl.alusrc == IMM) ? imm_x : iss[i].rd2;
            res = alu_ref(iss[i].ctl.alufunc, opa, opb, ovf);
            bad = (iss[i].ctl.msize == MSIZE2 && res[0]) ||
                  (iss[i].ctl.msize == MSIZE4 && res[1:0] != 2'b00);
            exp[i]              = '0;
            exp[i].valid        = iss[i].valid;
            exp[i].pc           = iss[i].pc;
            exp[i].alu_out      = (i == 1 && iss[i].ctl.is_link) ? iss[i].pc + 32'd8 : res;
            exp[i].srca         = iss[i].rd1;
            exp[i].srcb         = iss[i].rd2;
            exp[i].rdst         = iss[i].rdst;
            exp[i].ctl          = iss[i].ctl;
            exp[i].exc.overflow = ovf;
            exp[i].exc.adel     = bad && iss[i].ctl.memtoreg;
            exp[i].exc.ades     = bad && iss[i].ctl.memwrite;
            fault[i]            = exp[i].exc.adel || exp[i].exc.ades;
            if (fault[i]) exp[i].exc.vaddr = res;
            if (exp[i].exc.adel) exp[i].ctl.memtoreg = 1'b0;
            if (exp[i].exc.ades) exp[i].ctl.memwrite = 1'b0;
        end
        // older lane faults kill the younger lane
        if (fault[1]) begin
            exp[0].ctl.memtoreg = 1'b0;
            exp[0].ctl.memwrite = 1'b0;
        end
        if (exp[1].exc.overflow) exp[0].valid = 1'b0;
        md_lane = is_md(iss[1].ctl.op);
        exp[md_lane].hilo = hilo_ref(iss[md_lane].ctl.op, iss[md_lane].rd1, iss[md_lane].rd2);
        return exp;
    endfunction

    // kinds 0 reg alu, 1 imm alu, 2 shamt shift, 3 load, 4 store, 5 link, 6 mul/div
    function automatic issue_data_t gen_lane(int kind);
        issue_data_t d;
        d             = '0;
        d.valid       = (pick(8) != 0);
        d.pc          = next_rand() & 32'hffff_fffc;
        d.shamt       = shamt_t'(next_rand());
        d.imm         = imm_t'(next_rand());
        d.rd1         = rand_operand();
        d.rd2         = rand_operand();
        d.rdst        = reg_idx_t'(next_rand());
        d.ctl.op      = OP_ALU;
        d.ctl.alufunc = alufunc_t'(4'(pick(14)));
        d.ctl.zeroext = (pick(2) == 1);
        d.ctl.msize   = msize_t'(2'(pick(3)));
        case (kind)
            1: d.ctl.alusrc = IMM;
            2: begin
                d.ctl.shamt_valid = 1'b1;
                d.ctl.alufunc     = alufunc_t'(4'(pick(3) + 10));
            end
            3, 4: begin
                d.ctl.op       = (kind == 3) ? OP_LOAD : OP_STORE;
                d.ctl.alufunc  = ADDU;
                d.ctl.alusrc   = IMM;
                d.ctl.memtoreg = (kind == 3);
                d.ctl.memwrite = (kind == 4);
            end
            5: d.ctl.is_link = 1'b1;
            6: begin
                d.ctl.op = op_t'(3'(pick(4) + 1));
                if (pick(4) == 0) d.rd2 = '0;
            end
            default: ;
        endcase
        return d;
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_dword(string what, dword_t got, dword_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_exc(string what, exc_t got, exc_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is ovf=%b adel=%b ades=%b vaddr=%h", $time, what,
                     got.overflow, got.adel, got.ades, got.vaddr);
            $display("  expected ovf=%b adel=%b ades=%b vaddr=%h",
                     exp.overflow, exp.adel, exp.ades, exp.vaddr);
            stop_on_error();
        end
    endtask

    task automatic compare_pair();
        exec_pair_t exp;
        string      lane;
        exp = model_execute(issue_i);
        for (int i = 0; i < 2; i++) begin
            lane = $sformatf("lane %0d ", i);
            check_bit({lane, "valid"}, exec_o[i].valid, exp[i].valid);
            check_word({lane, "pc"}, exec_o[i].pc, exp[i].pc);
            check_word({lane, "alu_out"}, exec_o[i].alu_out, exp[i].alu_out);
            check_word({lane, "srca"}, exec_o[i].srca, exp[i].srca);
            check_word({lane, "srcb"}, exec_o[i].srcb, exp[i].srcb);
            check_word({lane, "rdst"}, word_t'(exec_o[i].rdst), word_t'(exp[i].rdst));
            check_word({lane, "ctl"}, word_t'(exec_o[i].ctl), word_t'(exp[i].ctl));
            check_dword({lane, "hilo"}, exec_o[i].hilo, exp[i].hilo);
            check_exc({lane, "exc"}, exec_o[i].exc, exp[i].exc);
        end
    endtask

    always @(posedge cmp_go) begin
        compare_pair();
        cmp_go = 1'b0;
    end

    initial begin
        int k1;
        int k0;
        int stall;
        int w;
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        issue_i     = '0;
        cmp_go      = 1'b0;
        rng_state   = 32'd23;
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        for (int n = 0; n < NUM_PAIRS; n++) begin
            @(posedge clk);
            #1;
            k1 = int'(pick(8));
            k0 = int'(pick(8));
            if (k1 == 7) k1 = 6;
            if (k0 == 7) k0 = 6;
            // regular back-to-back mul/div pairs in alternating lanes
            if (n % 16 == 0) k1 = 6;
            if (n % 16 == 1) k0 = 6;
            if (k1 == 6 && k0 == 6) begin
                if (n % 16 == 1) k1 = 0;
                else k0 = 1;
            end
            issue_i[1] = gen_lane(k1);
            issue_i[0] = gen_lane(k0);
            #2;
            for (stall = 0; stall < WAIT_LIMIT && e_wait_o; stall++) begin
                @(posedge clk);
                #3;
            end
            if (e_wait_o) begin
                $display("Timeout: the execute stage never finished a multiply/divide");
                $display("Simulation failed");
                $fatal(1, "stall timeout");
            end
            check_word("stall cycles", word_t'(stall), stall_ref(issue_i));
            cmp_go = 1'b1;
            for (w = 0; w < 4 && cmp_go; w++) begin
                #1;
            end
            if (cmp_go) begin
                $display("The compare process did not answer in time");
                $display("Simulation failed");
                $fatal(1, "compare timeout");
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
design/exec_pkg.sv
design/hilo_if.sv
design/exec_alu.sv
design/exec_multiplier.sv
design/exec_divider.sv
design/exec_hilo_unit.sv
design/dual_execute.sv
test/tb_dual_execute.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run; a $fatal in the testbench gives a failing status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_dual_execute -o sim_dual_execute
./obj_dir/sim_dual_execute
